/* Makefile */
# Verilator build and run of the load/store unit testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run lsu_tb and check $(LOG)"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f src.f \
		--top-module lsu_tb -Mdir obj_dir
	./obj_dir/Vlsu_tb | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then \
		echo "testbench reported failure"; exit 1; \
	fi
	@grep -q "sim passed" $(LOG) || (echo "no result in $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* source/lsu_defs.svh */
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// data and address width, one rv32 word
`define LSU_XLEN 32

// reorder buffer tag width
`define LSU_ROB_W 4

// request queue entries, also the number of credits after reset
// keep it a power of two (2, 4 or 8)
`define LSU_QDEPTH 4

`endif

/* source/lsu_pkg.sv */
`include "lsu_defs.svh"

package lsu_pkg;

        typedef logic [`LSU_XLEN-1:0]   word_t;
        typedef logic [`LSU_XLEN/8-1:0] mask_t;
        typedef logic [`LSU_ROB_W-1:0]  rob_idx_t;

        // rv32i load and store flavours
        typedef enum logic [2:0] {
                lb,
                lbu,
                lh,
                lhu,
                lw,
                sb,
                sh,
                sw
        } mem_op_e;

        // operation as it leaves the reservation station
        typedef struct packed {
                mem_op_e  op;
                word_t    base;
                word_t    imm;
                word_t    store_data;
                rob_idx_t rob_idx;
        } mem_issue_t;

        // request held in the queue, already lane aligned
        typedef struct packed {
                mem_op_e    op;
                word_t      addr;
                logic [1:0] offset;
                mask_t      rmask;
                mask_t      wmask;
                word_t      wdata;
                rob_idx_t   rob_idx;
        } mem_req_t;

        // result toward the reorder buffer
        typedef struct packed {
                rob_idx_t rob_idx;
                logic     is_load;
                word_t    addr;
                word_t    rd_data;
        } wb_t;

        typedef enum logic [1:0] {idle, wait_resp, finish} unit_state_e;

endpackage

/* source/lsu_top.sv */
module lsu_top (
        input  logic                clk,
        input  logic                rst,
        input  logic                issue_valid_i,
        input  lsu_pkg::mem_issue_t issue_i,
        output logic                issue_ready_o,
        output lsu_pkg::word_t      dmem_addr_o,
        output lsu_pkg::mask_t      dmem_rmask_o,
        output lsu_pkg::mask_t      dmem_wmask_o,
        output lsu_pkg::word_t      dmem_wdata_o,
        input  lsu_pkg::word_t      dmem_rdata_i,
        input  logic                dmem_resp_i,
        output logic                wb_valid_o,
        output lsu_pkg::wb_t        wb_o
);
        logic              push;
        lsu_pkg::mem_req_t req;
        logic              credit;
        logic              head_valid;
        lsu_pkg::mem_req_t head;
        logic              pop;

        mem_issue u_issue (
                .clk           (clk),
                .rst           (rst),
                .issue_valid_i (issue_valid_i),
                .issue_i       (issue_i),
                .issue_ready_o (issue_ready_o),
                .push_o        (push),
                .req_o         (req),
                .credit_i      (credit)
        );

        // program-order buffer between address generation and memory
        mem_req_queue u_queue (
                .clk          (clk),
                .rst          (rst),
                .push_i       (push),
                .req_i        (req),
                .pop_i        (pop),
                .head_valid_o (head_valid),
                .head_o       (head),
                .credit_o     (credit)
        );

        mem_unit u_unit (
                .clk          (clk),
                .rst          (rst),
                .head_valid_i (head_valid),
                .head_i       (head),
                .pop_o        (pop),
                .dmem_addr_o  (dmem_addr_o),
                .dmem_rmask_o (dmem_rmask_o),
                .dmem_wmask_o (dmem_wmask_o),
                .dmem_wdata_o (dmem_wdata_o),
                .dmem_rdata_i (dmem_rdata_i),
                .dmem_resp_i  (dmem_resp_i),
                .wb_valid_o   (wb_valid_o),
                .wb_o         (wb_o)
        );

endmodule

/* source/mem_issue.sv */
`include "lsu_defs.svh"

module mem_issue (
        input  logic                clk,
        input  logic                rst,
        input  logic                issue_valid_i,
        input  lsu_pkg::mem_issue_t issue_i,
        output logic                issue_ready_o,
        output logic                push_o,
        output lsu_pkg::mem_req_t   req_o,
        input  logic                credit_i
);
        localparam int CNT_W = $clog2(`LSU_QDEPTH + 1);

        logic [CNT_W-1:0]  credit_cnt;
        logic              accept;
        logic              is_store;
        lsu_pkg::word_t    eff_addr;
        logic [1:0]        offset;
        lsu_pkg::mask_t    size_mask;
        lsu_pkg::mask_t    lane_mask;
        lsu_pkg::mem_req_t req_next;

        assign issue_ready_o = (credit_cnt != '0);
        assign accept = issue_valid_i && issue_ready_o;

        assign eff_addr = issue_i.base + issue_i.imm;
        assign offset = eff_addr[1:0];
        assign is_store = issue_i.op inside {lsu_pkg::sb, lsu_pkg::sh, lsu_pkg::sw};

        // access size, then move it to the addressed bytes
        always_comb begin
                case (issue_i.op)
                lsu_pkg::lb, lsu_pkg::lbu, lsu_pkg::sb: size_mask = 4'b0001;
                lsu_pkg::lh, lsu_pkg::lhu, lsu_pkg::sh: size_mask = 4'b0011;
                default: size_mask = 4'b1111;
                endcase
        end

        assign lane_mask = size_mask << offset;

        always_comb begin
                req_next.op = issue_i.op;
                req_next.addr = {eff_addr[`LSU_XLEN-1:2], 2'b00};
                req_next.offset = offset;
                req_next.rmask = is_store ? '0 : lane_mask;
                req_next.wmask = is_store ? lane_mask : '0;
                req_next.wdata = issue_i.store_data << {offset, 3'b000};
                req_next.rob_idx = issue_i.rob_idx;
        end

        // a credit is spent at acceptance, the push follows one cycle later
        always_ff @(posedge clk) begin
                if (rst) begin
                        credit_cnt <= CNT_W'(`LSU_QDEPTH);
                        push_o <= 1'b0;
                end else begin
                        push_o <= accept;
                        case ({accept, credit_i})
                        2'b10: credit_cnt <= credit_cnt - 1'b1;
                        2'b01: credit_cnt <= credit_cnt + 1'b1;
                        default: credit_cnt <= credit_cnt;
                        endcase
                end
        end

        always_ff @(posedge clk) begin
                if (accept) begin
                        req_o <= req_next;
                end
        end

        // misaligned halfword and word accesses are never issued
        a_half_aligned: assert property (@(posedge clk) disable iff (rst)
                accept && (issue_i.op inside {lsu_pkg::lh, lsu_pkg::lhu, lsu_pkg::sh})
                |-> !eff_addr[0]);
        a_word_aligned: assert property (@(posedge clk) disable iff (rst)
                accept && (issue_i.op inside {lsu_pkg::lw, lsu_pkg::sw})
                |-> (eff_addr[1:0] == 2'b00));

        // queue must only hand back credits that were spent
        a_credit_cap: assert property (@(posedge clk) disable iff (rst)
                credit_cnt <= CNT_W'(`LSU_QDEPTH));

endmodule

/* source/mem_req_queue.sv */
`include "lsu_defs.svh"

module mem_req_queue (
        input  logic              clk,
        input  logic              rst,
        input  logic              push_i,
        input  lsu_pkg::mem_req_t req_i,
        input  logic              pop_i,
        output logic              head_valid_o,
        output lsu_pkg::mem_req_t head_o,
        output logic              credit_o
);
        localparam int PTR_W = $clog2(`LSU_QDEPTH);
        localparam int CNT_W = $clog2(`LSU_QDEPTH + 1);
        localparam logic [PTR_W-1:0] LAST = PTR_W'(`LSU_QDEPTH - 1);

        lsu_pkg::mem_req_t entries [`LSU_QDEPTH];
        logic [PTR_W-1:0]  wr_ptr;
        logic [PTR_W-1:0]  rd_ptr;
        logic [CNT_W-1:0]  count;
        logic              do_pop;

        assign head_valid_o = (count != '0);
        assign head_o = entries[rd_ptr];
        assign do_pop = pop_i && head_valid_o;

        // each entry leaving frees one slot for the producer
        assign credit_o = do_pop;

        always_ff @(posedge clk) begin
                if (push_i) begin
                        entries[wr_ptr] <= req_i;
                end
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        count <= '0;
                end else begin
                        if (push_i) begin
                                wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
                        end
                        if (do_pop) begin
                                rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
                        end
                        case ({push_i, do_pop})
                        2'b10: count <= count + 1'b1;
                        2'b01: count <= count - 1'b1;
                        default: count <= count;
                        endcase
                end
        end

        // credit flow in the producer keeps a full queue from seeing a push
        a_no_push_full: assert property (@(posedge clk) disable iff (rst)
                push_i |-> (count != CNT_W'(`LSU_QDEPTH)));
        a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
                pop_i |-> head_valid_o);

endmodule

/* source/mem_unit.sv */
`include "lsu_defs.svh"

module mem_unit (
        input  logic              clk,
        input  logic              rst,
        input  logic              head_valid_i,
        input  lsu_pkg::mem_req_t head_i,
        output logic              pop_o,
        output lsu_pkg::word_t    dmem_addr_o,
        output lsu_pkg::mask_t    dmem_rmask_o,
        output lsu_pkg::mask_t    dmem_wmask_o,
        output lsu_pkg::word_t    dmem_wdata_o,
        input  lsu_pkg::word_t    dmem_rdata_i,
        input  logic              dmem_resp_i,
        output logic              wb_valid_o,
        output lsu_pkg::wb_t      wb_o
);
        lsu_pkg::unit_state_e state;
        lsu_pkg::mem_req_t    cur_q;
        lsu_pkg::word_t       lane_data;
        lsu_pkg::word_t       load_data;
        logic                 cur_is_load;
        logic                 resp_done;

        // only take a new request once the previous one has written back
        assign pop_o = (state == lsu_pkg::idle) && head_valid_i;

        assign dmem_addr_o = cur_q.addr;
        assign dmem_wdata_o = cur_q.wdata;

        // request is live only in wait_resp, so the masks drop at the response edge
        assign dmem_rmask_o = (state == lsu_pkg::wait_resp) ? cur_q.rmask : '0;
        assign dmem_wmask_o = (state == lsu_pkg::wait_resp) ? cur_q.wmask : '0;

        assign cur_is_load = cur_q.op inside {lsu_pkg::lb, lsu_pkg::lbu, lsu_pkg::lh,
                                              lsu_pkg::lhu, lsu_pkg::lw};
        assign resp_done = (state == lsu_pkg::wait_resp) && dmem_resp_i;

        // addressed byte lane down to bit 0
        assign lane_data = dmem_rdata_i >> {cur_q.offset, 3'b000};

        always_comb begin
                case (cur_q.op)
                lsu_pkg::lb:
                        load_data = {{(`LSU_XLEN-8){lane_data[7]}}, lane_data[7:0]};
                lsu_pkg::lbu:
                        load_data = {{(`LSU_XLEN-8){1'b0}}, lane_data[7:0]};
                lsu_pkg::lh:
                        load_data = {{(`LSU_XLEN-16){lane_data[15]}}, lane_data[15:0]};
                lsu_pkg::lhu:
                        load_data = {{(`LSU_XLEN-16){1'b0}}, lane_data[15:0]};
                default:
                        load_data = lane_data;
                endcase
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        state <= lsu_pkg::idle;
                end else begin
                        case (state)
                        lsu_pkg::idle: begin
                                if (head_valid_i) begin
                                        state <= lsu_pkg::wait_resp;
                                end
                        end
                        lsu_pkg::wait_resp: begin
                                if (dmem_resp_i) begin
                                        state <= lsu_pkg::finish;
                                end
                        end
                        default: state <= lsu_pkg::idle;
                        endcase
                end
        end

        always_ff @(posedge clk) begin
                if (pop_o) begin
                        cur_q <= head_i;
                end
                if (resp_done) begin
                        wb_o.rob_idx <= cur_q.rob_idx;
                        wb_o.is_load <= cur_is_load;
                        wb_o.addr <= {cur_q.addr[`LSU_XLEN-1:2], cur_q.offset};
                        // stores report no data
                        wb_o.rd_data <= cur_is_load ? load_data : '0;
                end
        end

        assign wb_valid_o = (state == lsu_pkg::finish);

        a_one_dir: assert property (@(posedge clk) disable iff (rst)
                !((|dmem_rmask_o) && (|dmem_wmask_o)));

        // memory answers only a live request
        a_resp_live: assert property (@(posedge clk) disable iff (rst)
                dmem_resp_i |-> ((|dmem_rmask_o) || (|dmem_wmask_o)));

endmodule

/* src.f */
+incdir+source
source/lsu_pkg.sv
source/mem_issue.sv
source/mem_req_queue.sv
source/mem_unit.sv
source/lsu_top.sv
verif/dmem_model.sv
verif/lsu_tb.sv

/* verif/dmem_model.sv */
module dmem_model (
        input  logic           clk,
        input  logic           rst,
        input  logic           stall_i,
        input  lsu_pkg::word_t addr_i,
        input  lsu_pkg::mask_t rmask_i,
        input  lsu_pkg::mask_t wmask_i,
        input  lsu_pkg::word_t wdata_i,
        output lsu_pkg::word_t rdata_o,
        output logic           resp_o
);
        lsu_pkg::word_t mem [64];
        int             delay;
        logic           live;
        logic [5:0]     idx;

        assign live = (|rmask_i) || (|wmask_i);
        assign idx = addr_i[7:2];

        // known contents with every word different
        initial begin
                for (int i = 0; i < 64; i++) begin
                        mem[i] = 32'h9e37_79b9 * (i + 1);
                end
        end

        // delay picked when a request shows up
        // stall holds the last step
        always @(posedge clk) begin
                if (rst) begin
                        resp_o <= 1'b0;
                        rdata_o <= '0;
                        delay <= 0;
                end else begin
                        resp_o <= 1'b0;
                        if (live && !resp_o) begin
                                if (delay == 0) begin
                                        delay <= $urandom_range(5, 1);
                                end else if (delay > 1) begin
                                        delay <= delay - 1;
                                end else if (!stall_i) begin
                                        resp_o <= 1'b1;
                                        delay <= 0;
                                        rdata_o <= mem[idx];
                                        for (int b = 0; b < 4; b++) begin
                                                if (wmask_i[b]) begin
                                                        mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
                                                end
                                        end
                                end
                        end
                end
        end

endmodule

/* verif/lsu_tb.sv */
`include "lsu_defs.svh"

module lsu_tb;
        localparam int TMO = 200;
        localparam int NWORDS = 64;

        logic                clk;
        logic                rst;
        logic                issue_valid_i;
        lsu_pkg::mem_issue_t issue_i;
        logic                issue_ready_o;
        lsu_pkg::word_t      dmem_addr_o;
        lsu_pkg::mask_t      dmem_rmask_o;
        lsu_pkg::mask_t      dmem_wmask_o;
        lsu_pkg::word_t      dmem_wdata_o;
        lsu_pkg::word_t      dmem_rdata_i;
        logic                dmem_resp_i;
        logic                wb_valid_o;
        lsu_pkg::wb_t        wb_o;
        logic                stall;

        lsu_pkg::word_t      shadow [NWORDS];
        lsu_pkg::wb_t        exp_q [$];
        logic [7:0]          mask_q [$];
        lsu_pkg::wb_t        exp_head;
        logic [7:0]          exp_mask;
        logic                exp_valid;
        int                  pending;
        int                  acc_count;
        int                  wb_count;
        int                  errors;
        int                  err_mark;
        int                  tests_run;
        int                  tests_failed;
        lsu_pkg::rob_idx_t   next_rob;

        lsu_top UUT (.*);

        dmem_model mem_model (
                .clk     (clk),
                .rst     (rst),
                .stall_i (stall),
                .addr_i  (dmem_addr_o),
                .rmask_i (dmem_rmask_o),
                .wmask_i (dmem_wmask_o),
                .wdata_i (dmem_wdata_o),
                .rdata_o (dmem_rdata_i),
                .resp_o  (dmem_resp_i)
        );

        initial begin
                clk = 1'b0;
                forever #20 clk = ~clk;
        end

        // expected writeback of one operation and the shadow update of a store
        function automatic lsu_pkg::wb_t predict_wb(input lsu_pkg::mem_issue_t op);
                lsu_pkg::wb_t   wb;
                lsu_pkg::word_t addr;
                lsu_pkg::word_t word;
                lsu_pkg::word_t lane;
                lsu_pkg::word_t stmask;
                int             shamt;
                addr = op.base + op.imm;
                word = shadow[addr[7:2]];
                shamt = 8 * int'(addr[1:0]);
                lane = word >> shamt;
                wb.rob_idx = op.rob_idx;
                wb.addr = addr;
                wb.is_load = 1'b1;
                case (op.op)
                lsu_pkg::lb: wb.rd_data = {{24{lane[7]}}, lane[7:0]};
                lsu_pkg::lbu: wb.rd_data = {24'h0, lane[7:0]};
                lsu_pkg::lh: wb.rd_data = {{16{lane[15]}}, lane[15:0]};
                lsu_pkg::lhu: wb.rd_data = {16'h0, lane[15:0]};
                lsu_pkg::lw: wb.rd_data = word;
                default: begin
                        wb.is_load = 1'b0;
                        wb.rd_data = '0;
                        stmask = (op.op == lsu_pkg::sb) ? 32'h0000_00ff :
                                 (op.op == lsu_pkg::sh) ? 32'h0000_ffff : 32'hffff_ffff;
                        stmask = stmask << shamt;
                        shadow[addr[7:2]] = (word & ~stmask) | ((op.store_data << shamt) & stmask);
                end
                endcase
                return wb;
        endfunction

        // byte enables of one access with the read lanes above the write lanes
        function automatic logic [7:0] access_mask(input lsu_pkg::mem_issue_t op);
                lsu_pkg::word_t addr;
                logic [3:0]     lanes;
                int             nbytes;
                int             off;
                logic [7:0]     both;
                addr = op.base + op.imm;
                off = int'(addr[1:0]);
                case (op.op)
                lsu_pkg::lb, lsu_pkg::lbu, lsu_pkg::sb: nbytes = 1;
                lsu_pkg::lh, lsu_pkg::lhu, lsu_pkg::sh: nbytes = 2;
                default: nbytes = 4;
                endcase
                for (int b = 0; b < 4; b++) begin
                        lanes[b] = (b >= off) && (b < off + nbytes);
                end
                if (op.op inside {lsu_pkg::sb, lsu_pkg::sh, lsu_pkg::sw}) begin
                        both = {4'b0000, lanes};
                end else begin
                        both = {lanes, 4'b0000};
                end
                return both;
        endfunction

        // word address plus the nearest offset that the access size allows
        function automatic lsu_pkg::word_t legal_addr(input lsu_pkg::mem_op_e op, input int w,
                                                      input int off);
                int o;
                case (op)
                lsu_pkg::lb, lsu_pkg::lbu, lsu_pkg::sb: o = off;
                lsu_pkg::lh, lsu_pkg::lhu, lsu_pkg::sh: o = off & 2;
                default: o = 0;
                endcase
                return lsu_pkg::word_t'(w * 4 + o);
        endfunction

        // in-order scoreboard read by the negedge checks
        always @(posedge clk) begin
                if (rst) begin
                        exp_q.delete();
                        mask_q.delete();
                        acc_count = 0;
                        wb_count = 0;
                end else begin
                        if (wb_valid_o) begin
                                wb_count++;
                                if (exp_q.size() > 0) begin
                                        void'(exp_q.pop_front());
                                        void'(mask_q.pop_front());
                                end
                        end
                        if (issue_valid_i && issue_ready_o) begin
                                exp_q.push_back(predict_wb(issue_i));
                                mask_q.push_back(access_mask(issue_i));
                                acc_count++;
                        end
                end
                pending = exp_q.size();
                exp_valid = (pending > 0);
                if (exp_valid) begin
                        exp_head = exp_q[0];
                        exp_mask = mask_q[0];
                end
        end

        a_reset_state: assert property (@(posedge clk) $fell(rst) |->
                (issue_ready_o && !wb_valid_o && dmem_rmask_o == '0 && dmem_wmask_o == '0))
                else begin
                        errors++;
                        $display("error at %0t: outputs not in their reset state", $time);
                end

        a_wb_expected: assert property (@(negedge clk) disable iff (rst) wb_valid_o |-> exp_valid)
                else begin
                        errors++;
                        $display("error at %0t: writeback with no operation in flight", $time);
                end

        a_wb_match: assert property (@(negedge clk) disable iff (rst)
                (wb_valid_o && exp_valid) |-> (wb_o == exp_head))
                else begin
                        errors++;
                        $display("mismatch at %0t: wb_o expected %h got %h", $time, exp_head, wb_o);
                end

        // live request carries the lanes of the oldest operation in flight
        a_mask_match: assert property (@(negedge clk) disable iff (rst)
                ((|dmem_rmask_o) || (|dmem_wmask_o))
                |-> ({dmem_rmask_o, dmem_wmask_o} == exp_mask))
                else begin
                        errors++;
                        $display("mismatch at %0t: dmem_rmask_o/dmem_wmask_o expected %b got %b",
                                 $time, exp_mask, {dmem_rmask_o, dmem_wmask_o});
                end

        // queue entries plus the one held in the unit
        a_inflight: assert property (@(negedge clk) disable iff (rst)
                pending <= `LSU_QDEPTH + 1)
                else begin
                        errors++;
                        $display("error at %0t: %0d operations in flight", $time, pending);
                end

        task automatic drive_op(input lsu_pkg::mem_op_e op, input lsu_pkg::word_t addr,
                                input lsu_pkg::word_t data);
                issue_i.op = op;
                issue_i.imm = lsu_pkg::word_t'($urandom_range(32, 0)) - 32'd16;
                issue_i.base = addr - issue_i.imm;
                issue_i.store_data = data;
                issue_i.rob_idx = next_rob;
                issue_valid_i = 1'b1;
                next_rob++;
        endtask

        task automatic wait_accept();
                int t;
                t = 0;
                while (!issue_ready_o && t < TMO) begin
                        @(negedge clk);
                        t++;
                end
                if (!issue_ready_o) begin
                        errors++;
                        $display("error at %0t: issue_ready_o stuck low", $time);
                end
                @(negedge clk);
                issue_valid_i = 1'b0;
        endtask

        task automatic send(input lsu_pkg::mem_op_e op, input lsu_pkg::word_t addr,
                            input lsu_pkg::word_t data);
                drive_op(op, addr, data);
                wait_accept();
        endtask

        task automatic drain();
                int t;
                t = 0;
                while (pending != 0 && t < TMO) begin
                        @(negedge clk);
                        t++;
                end
                if (pending != 0) begin
                        errors++;
                        $display("error at %0t: %0d operations never wrote back", $time, pending);
                end
        endtask

        task automatic end_test(input string name);
                tests_run++;
                if (errors > err_mark) begin
                        tests_failed++;
                        $display("test %0d %s: failed, %0d errors", tests_run, name,
                                 errors - err_mark);
                end else begin
                        $display("test %0d %s: ok", tests_run, name);
                end
                err_mark = errors;
        endtask

        task automatic check_counts();
                assert (acc_count == wb_count) else begin
                        errors++;
                        $display("mismatch at %0t: writebacks expected %0d got %0d", $time,
                                 acc_count, wb_count);
                end
        endtask

        initial begin
                lsu_pkg::mem_op_e op;
                lsu_pkg::word_t   addr;
                int               low;
                int               t;
                void'($urandom(32'h933d));
                rst = 1'b1;
                issue_valid_i = 1'b0;
                issue_i = '0;
                stall = 1'b0;
                errors = 0;
                err_mark = 0;
                tests_run = 0;
                tests_failed = 0;
                next_rob = '0;
                repeat (3) @(negedge clk);
                rst = 1'b0;
                for (int i = 0; i < NWORDS; i++) begin
                        shadow[i] = mem_model.mem[i];
                end
                @(negedge clk);
                end_test("reset state");

                for (int w = 5; w < NWORDS; w += 37) begin
                        for (int k = 0; k < 5; k++) begin
                                for (int off = 0; off < 4; off++) begin
                                        op = lsu_pkg::mem_op_e'(3'(k));
                                        send(op, legal_addr(op, w, off), '0);
                                end
                        end
                end
                drain();
                end_test("load extension");

                // each store is read back by a full word load
                for (int k = 5; k < 8; k++) begin
                        for (int off = 0; off < 4; off++) begin
                                op = lsu_pkg::mem_op_e'(3'(k));
                                addr = legal_addr(op, 10, off);
                                send(op, addr, $urandom());
                                send(lsu_pkg::lw, legal_addr(lsu_pkg::lw, 10, 0), '0);
                        end
                end
                drain();
                end_test("stores");

                for (int w = 0; w < 12; w++) begin
                        send(lsu_pkg::lw, legal_addr(lsu_pkg::lw, w * 5, 0), '0);
                end
                drain();
                check_counts();
                end_test("order and tags");

                stall = 1'b1;
                for (int w = 0; w < `LSU_QDEPTH + 1; w++) begin
                        send(lsu_pkg::lw, legal_addr(lsu_pkg::lw, w + 20, 0), '0);
                end
                drive_op(lsu_pkg::lbu, legal_addr(lsu_pkg::lbu, 30, 3), '0);
                low = 0;
                t = 0;
                while (low < 2 && t < TMO) begin
                        @(negedge clk);
                        low = issue_ready_o ? 0 : low + 1;
                        t++;
                end
                if (low < 2) begin
                        errors++;
                        $display("error at %0t: issue_ready_o never dropped", $time);
                end
                assert (pending == `LSU_QDEPTH + 1) else begin
                        errors++;
                        $display("mismatch at %0t: in-flight count expected %0d got %0d", $time,
                                 `LSU_QDEPTH + 1, pending);
                end
                stall = 1'b0;
                wait_accept();
                drain();
                check_counts();
                end_test("back-pressure");

                for (int n = 0; n < 200; n++) begin
                        op = lsu_pkg::mem_op_e'(3'($urandom_range(7, 0)));
                        addr = legal_addr(op, int'($urandom_range(NWORDS - 1, 0)),
                                          int'($urandom_range(3, 0)));
                        send(op, addr, $urandom());
                        repeat ($urandom_range(3, 0)) @(negedge clk);
                end
                drain();
                check_counts();
                for (int i = 0; i < NWORDS; i++) begin
                        assert (mem_model.mem[i] == shadow[i]) else begin
                                errors++;
                                $display("mismatch at %0t: mem[%0d] expected %h got %h", $time,
                                         i, shadow[i], mem_model.mem[i]);
                        end
                end
                end_test("random mix");

                $display("tests %0d, failed %0d, errors %0d, accepted %0d, writebacks %0d",
                         tests_run, tests_failed, errors, acc_count, wb_count);
                if (errors == 0) begin
                        $display("sim passed");
                end else begin
                        $display("sim failed");
                end
                $finish;
        end

endmodule
